//--- Bender.yml
package:
  name: audio_out

sources:
  - design/audio_pkg.sv
  - design/mix_feed_if.sv
  - design/sample_mixer.sv
  - design/sd_dac_channel.sv
  - design/audio_out_top.sv
  - target: test
    files:
      - tb/audio_out_assert.sv
      - tb/audio_out_tb.sv

//--- compile.f
design/audio_pkg.sv
design/mix_feed_if.sv
design/sample_mixer.sv
design/sd_dac_channel.sv
design/audio_out_top.sv
tb/audio_out_assert.sv
tb/audio_out_tb.sv

//--- design/audio_out_top.sv
/*
 * audio output path top
 * sample mixer feeding one sigma-delta converter per side
 */

`timescale 1ns/10ps

module audio_out_top import audio_pkg::*; #(
	parameter int SAMPLE_DIV = 16                    // sample tick divider, 2 or more
) (
	input  logic                   clk_32,
	input  logic                   xsint,           // async reset, low active
	input  logic [psg_level_w-1:0] psg_a_i,         // ym channel levels
	input  logic [psg_level_w-1:0] psg_b_i,
	input  logic [psg_level_w-1:0] psg_c_i,
	input  logic [dma_level_w-1:0] dma_l_i,         // ste dma sound levels
	input  logic [dma_level_w-1:0] dma_r_i,
	input  logic                   psg_stereo_i,
	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	output logic                   audio_l_o,       // left bitstream
	output logic                   audio_r_o        // right bitstream
);

	logic [num_sides-1:0] dac_bits;

	mix_feed_if feed ();

	sample_mixer #(
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_mixer (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.psg_a_i      (psg_a_i),
		.psg_b_i      (psg_b_i),
		.psg_c_i      (psg_c_i),
		.dma_l_i      (dma_l_i),
		.dma_r_i      (dma_r_i),
		.psg_stereo_i (psg_stereo_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.feed         (feed.mixer)
	);

	// one converter per side
	for (genvar i = 0; i < num_sides; i++) begin : g_dac
		sd_dac_channel #(
			.CH (i)
		) u_dac (
			.clk_32 (clk_32),
			.xsint  (xsint),
			.feed   (feed.converter),
			.bit_o  (dac_bits[i])
		);
	end

	assign audio_l_o = dac_bits[0];  // channel 0
	assign audio_r_o = dac_bits[1];  // channel 1

endmodule

//--- design/audio_pkg.sv
/*
 * audio output path shared definitions
 * level widths, signed offsets, mixed word type
 * and the enums used by the mixer and converters
 */

package audio_pkg;

	// input level widths
	localparam int psg_level_w = 8;   // one ym channel
	localparam int dma_level_w = 8;   // one ste dma sound side
	localparam int psg_sum_w   = 10;  // room for a+b+c

	// mixed word, psg and dma each widened to this
	localparam int mix_w = 15;

	// midpoints removed to get signed values
	localparam int psg_offset = 512;  // centre of the 10 bit sum
	localparam int dma_offset = 128;  // centre of an 8 bit level

	// left and right
	localparam int num_sides = 2;

	// one side after mixing, two's complement
	typedef logic signed [mix_w-1:0] mix_word_t;

	// psg channel routing
	typedef enum logic {
		MIX_MONO   = 1'b0,  // a+b+c on both sides
		MIX_STEREO = 1'b1   // a+b left, c+b right
	} mix_mode_e;

	// mixer holding register
	typedef enum logic {
		HOLD_EMPTY = 1'b0,
		HOLD_FULL  = 1'b1
	} hold_state_e;

endpackage

//--- design/mix_feed_if.sv
/*
 * mixer to converter feed
 * per side mixed words, holding register state
 * and the one cycle load strobe at the sample tick
 */

`timescale 1ns/10ps

interface mix_feed_if import audio_pkg::*; ();

	mix_word_t mix [num_sides];  // held words, index 0 left, 1 right
	logic      full;             // holding register occupied
	logic      load;             // converters take mix on this edge

	// mixer side drives everything
	modport mixer (
		output mix,
		output full,
		output load
	);

	// converters only listen, they never stall
	modport converter (
		input mix,
		input full,
		input load
	);

endinterface

//--- design/sample_mixer.sv
/*
 * sample mixer
 * takes psg and dma levels over valid/ready, offsets them to signed form,
 * widens and adds them into one 15 bit word per side, keeps one sample
 * in a holding register and hands it to the converters at the sample tick
 */

`timescale 1ns/10ps

module sample_mixer import audio_pkg::*; #(
	parameter int SAMPLE_DIV = 16                    // clk_32 cycles per sample tick
) (
	input  logic                   clk_32,
	input  logic                   xsint,           // async reset, low active
	input  logic [psg_level_w-1:0] psg_a_i,
	input  logic [psg_level_w-1:0] psg_b_i,
	input  logic [psg_level_w-1:0] psg_c_i,
	input  logic [dma_level_w-1:0] dma_l_i,
	input  logic [dma_level_w-1:0] dma_r_i,
	input  logic                   psg_stereo_i,    // taken with the sample
	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	mix_feed_if.mixer              feed
);

	localparam int cnt_w = $clog2(SAMPLE_DIV);

	logic [cnt_w-1:0]     tick_cnt;   // free running from reset release
	logic                 tick;       // last cycle of each sample period
	hold_state_e          hold_state;
	logic                 xfer;       // handshake completes this edge
	mix_mode_e            mode;
	logic [psg_sum_w-1:0] psg_a_x;
	logic [psg_sum_w-1:0] psg_b_x;
	logic [psg_sum_w-1:0] psg_c_x;
	logic [psg_sum_w-1:0] psg_sum [num_sides];
	logic [dma_level_w-1:0] dma_lvl [num_sides];
	mix_word_t            new_mix [num_sides];
	mix_word_t            hold_mix [num_sides];  // words waiting for the tick

	// signed psg and dma parts, each stretched to mix_w and added
	function automatic mix_word_t mix_side(
		input logic [psg_sum_w-1:0]   sum,
		input logic [dma_level_w-1:0] lvl
	);
		logic [psg_sum_w-1:0]   p;
		logic [dma_level_w-1:0] d;
		logic [mix_w-1:0]       p_w;
		logic [mix_w-1:0]       d_w;
		p   = sum - psg_sum_w'(psg_offset);  // wraps mod 2^10
		d   = lvl - dma_level_w'(dma_offset); // wraps mod 2^8
		// sign, value, then top bits repeated below it
		p_w = {p[psg_sum_w-1], p, p[psg_sum_w-1 -: 4]};
		d_w = {d[dma_level_w-1], d, d[dma_level_w-1 -: 6]};
		return mix_word_t'(p_w + d_w);        // carry out dropped
	endfunction

	// sample period counter, fixed phase from reset
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;  // wrap
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == cnt_w'(SAMPLE_DIV - 1));

	assign in_ready_o = (hold_state == HOLD_EMPTY);
	assign xfer       = in_valid_i && in_ready_o;

	// psg routing
	assign mode    = psg_stereo_i ? MIX_STEREO : MIX_MONO;
	assign psg_a_x = psg_sum_w'(psg_a_i);  // zero extend
	assign psg_b_x = psg_sum_w'(psg_b_i);
	assign psg_c_x = psg_sum_w'(psg_c_i);

	always_comb begin
		if (mode == MIX_STEREO) begin
			psg_sum[0] = psg_a_x + psg_b_x;  // b shared as centre
			psg_sum[1] = psg_c_x + psg_b_x;
		end else begin
			psg_sum[0] = psg_a_x + psg_b_x + psg_c_x;
			psg_sum[1] = psg_a_x + psg_b_x + psg_c_x;
		end
	end

	assign dma_lvl[0] = dma_l_i;
	assign dma_lvl[1] = dma_r_i;

	always_comb begin
		for (int s = 0; s < num_sides; s++) begin
			new_mix[s] = mix_side(psg_sum[s], dma_lvl[s]);
		end
	end

	// holding register state, filled by handshake, drained by tick
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hold_state <= HOLD_EMPTY;
		end else begin
			unique case (hold_state)
				HOLD_EMPTY: if (in_valid_i) hold_state <= HOLD_FULL;
				HOLD_FULL:  if (tick)       hold_state <= HOLD_EMPTY;  // load edge
				default:                    hold_state <= HOLD_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk_32) begin
		if (xfer) begin
			hold_mix <= new_mix;
		end
	end

	// feed to the converters
	assign feed.mix  = hold_mix;
	assign feed.full = (hold_state == HOLD_FULL);
	assign feed.load = tick && (hold_state == HOLD_FULL);  // one cycle strobe

endmodule

//--- design/sd_dac_channel.sv
/*
 * first order sigma-delta converter, one side
 * offset binary word into a 15 bit error accumulator,
 * the carry out is the registered bitstream
 */

`timescale 1ns/10ps

module sd_dac_channel import audio_pkg::*; #(
	parameter int CH = 0                 // side to take, 0 left 1 right
) (
	input  logic          clk_32,
	input  logic          xsint,         // async reset, low active
	mix_feed_if.converter feed,
	output logic          bit_o          // one bit audio stream
);

	mix_word_t        cur_word;          // word in use for this side
	logic [mix_w-1:0] ob_word;           // offset binary form
	logic [mix_w-1:0] accum;             // error accumulator
	logic [mix_w:0]   acc_next;          // with carry

	// flip the sign bit, -16384 maps to 0 and 16383 to full scale
	assign ob_word  = {~cur_word[mix_w-1], cur_word[mix_w-2:0]};
	assign acc_next = {1'b0, accum} + {1'b0, ob_word};

	// new word on load, used from the next edge on
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cur_word <= '0;
		end else if (feed.load && feed.full) begin
			cur_word <= feed.mix[CH];
		end
	end

	// accumulate every clk_32 cycle
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			accum <= '0;
			bit_o <= 1'b0;
		end else begin
			accum <= acc_next[mix_w-1:0];  // residue kept
			bit_o <= acc_next[mix_w];      // carry out is the pulse
		end
	end

endmodule

//--- tb/audio_out_assert.sv
/*
 * sample mixer protocol assertions
 * handshake ready against holding state, load strobe rules
 */

`timescale 1ns/10ps

module audio_out_assert (
	input logic clk_32,
	input logic xsint,       // async reset, low active
	input logic in_ready_o,
	input logic full,        // holding register occupied
	input logic load,        // converter strobe
	input logic tick         // sample period tick
);

	int fail_count = 0;      // failed assertions so far

	// strobe only with a sample waiting
	a_load_full: assert property (@(posedge clk_32) disable iff (!xsint) load |-> full)
		else begin
			fail_count++;
			$error("load raised with the holding register empty");
		end

	// ready is the empty holding register
	a_ready_empty: assert property (@(posedge clk_32) disable iff (!xsint)
		in_ready_o == !full)
		else begin
			fail_count++;
			$error("in_ready_o does not follow the holding register state");
		end

	a_load_tick: assert property (@(posedge clk_32) disable iff (!xsint) load |-> tick)
		else begin
			fail_count++;
			$error("load outside a tick cycle");
		end

	// single cycle pulse
	a_load_pulse: assert property (@(posedge clk_32) disable iff (!xsint) load |=> !load)
		else begin
			fail_count++;
			$error("load held longer than one cycle");
		end

endmodule

bind sample_mixer audio_out_assert u_assert (
	.clk_32     (clk_32),
	.xsint      (xsint),
	.in_ready_o (in_ready_o),
	.full       (feed.full),
	.load       (feed.load),
	.tick       (tick)
);

//--- tb/audio_out_tb.sv
/*
 * audio output path testbench
 * random psg/dma samples over valid/ready against a cycle model
 * of the sample tick, holding register, mixing and both accumulators
 */

`timescale 1ns/10ps

module audio_out_tb import audio_pkg::*; ();

	localparam int div        = 16;      // sample tick divider under test
	localparam int n_mono     = 64;
	localparam int n_stereo   = 64;
	localparam int n_bp       = 96;
	localparam int dens_len   = 2048;    // cycles counted after the load
	localparam int gap_max    = 24;      // idle cycles between samples
	localparam int smp_budget = gap_max + 2 * div + 2;
	localparam int run_cycles = 20 + (n_mono + n_stereo + n_bp + 1) * smp_budget
		+ 4 * (2 * div + 4) + dens_len;

	logic                   clk_32;
	logic                   xsint;
	logic [psg_level_w-1:0] psg_a_i;
	logic [psg_level_w-1:0] psg_b_i;
	logic [psg_level_w-1:0] psg_c_i;
	logic [dma_level_w-1:0] dma_l_i;
	logic [dma_level_w-1:0] dma_r_i;
	logic                   psg_stereo_i;
	logic                   in_valid_i;
	logic                   in_ready_o;
	logic                   audio_l_o;
	logic                   audio_r_o;

	// model state
	int               m_cnt;
	logic             m_full;
	logic [mix_w-1:0] m_hold [num_sides];
	logic [mix_w-1:0] m_word [num_sides];
	logic [mix_w-1:0] m_acc  [num_sides];
	logic             m_bit  [num_sides];

	int   seed;
	logic check_on;
	int   n_checks;
	int   n_errors;
	int   n_tests;
	int   n_fail_tests;
	int   side_diff;     // cycles where the two outputs differ
	int   xfer_seen;
	int   load_seen;

	audio_out_top #(
		.SAMPLE_DIV (div)
	) UUT (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.psg_a_i      (psg_a_i),
		.psg_b_i      (psg_b_i),
		.psg_c_i      (psg_c_i),
		.dma_l_i      (dma_l_i),
		.dma_r_i      (dma_r_i),
		.psg_stereo_i (psg_stereo_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.audio_l_o    (audio_l_o),
		.audio_r_o    (audio_r_o)
	);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32;  // 20 ns period
	end

	// expected mixed word for one side, straight from the mixing rule
	function automatic logic [mix_w-1:0] expected_mix(
		input logic [7:0] a,
		input logic [7:0] b,
		input logic [7:0] c,
		input logic [7:0] dma,
		input logic       st,
		input int         side
	);
		int               psg;
		logic [9:0]       p;
		logic [7:0]       d;
		logic [mix_w-1:0] p15;
		logic [mix_w-1:0] d15;
		if (st) psg = (side == 0) ? int'(a) + int'(b) : int'(c) + int'(b);
		else psg = int'(a) + int'(b) + int'(c);
		p   = 10'(psg - 512);              // signed psg part
		d   = 8'(int'(dma) - 128);         // signed dma part
		p15 = {p[9], 14'b0} | (15'(p) << 4) | 15'(p >> 6);
		d15 = {d[7], 14'b0} | (15'(d) << 6) | 15'(d >> 2);
		return p15 + d15;                  // wraps at 2^15
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] t=%0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// model advances on every edge, from pre-edge inputs
	always @(posedge clk_32) begin : model
		logic [mix_w:0] sum;
		logic           tick;
		logic           load;
		logic           xfer;
		if (!xsint) begin
			m_cnt  = 0;
			m_full = 1'b0;
			for (int s = 0; s < num_sides; s++) begin
				m_word[s] = '0;
				m_acc[s]  = '0;
				m_bit[s]  = 1'b0;
			end
		end else begin
			tick = (m_cnt == div - 1);
			load = tick && m_full;
			xfer = in_valid_i && !m_full;
			for (int s = 0; s < num_sides; s++) begin
				sum       = {1'b0, m_acc[s]} + {1'b0, m_word[s] ^ 15'h4000};  // offset binary
				m_acc[s]  = sum[mix_w-1:0];
				m_bit[s]  = sum[mix_w];
				if (load) m_word[s] = m_hold[s];  // old word used this edge
				if (xfer) begin
					m_hold[s] = expected_mix(psg_a_i, psg_b_i, psg_c_i,
						(s == 0) ? dma_l_i : dma_r_i, psg_stereo_i, s);
				end
			end
			if (xfer) m_full = 1'b1;
			else if (load) m_full = 1'b0;
			m_cnt = tick ? 0 : m_cnt + 1;
		end
	end

	// handshake and load counts, taken before the edge that acts on them
	always @(negedge clk_32) begin
		if (xsint && in_valid_i && in_ready_o) xfer_seen++;
		if (UUT.feed.load) load_seen++;
	end

	// compare mid cycle, outputs settled
	always @(negedge clk_32) begin
		if (check_on) begin
			check_equal("in_ready_o", in_ready_o, !m_full);
			check_equal("audio_l_o", audio_l_o, m_bit[0]);
			check_equal("audio_r_o", audio_r_o, m_bit[1]);
			if (audio_l_o != audio_r_o) side_diff++;
		end
	end

	// returns after the first rising edge with in_ready_o high before it
	task automatic wait_ready_edge();
		logic rdy;
		do begin
			@(negedge clk_32);
			rdy = in_ready_o;  // settled value seen by the next edge
			@(posedge clk_32);
		end while (!rdy);
	endtask

	// drive one sample and hold it until the transfer edge
	task automatic offer_sample(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] c, input logic [7:0] l, input logic [7:0] r, input logic st);
		psg_a_i      <= a;
		psg_b_i      <= b;
		psg_c_i      <= c;
		dma_l_i      <= l;
		dma_r_i      <= r;
		psg_stereo_i <= st;
		in_valid_i   <= 1'b1;
		wait_ready_edge();
	endtask

	// mode_sel 0 mono, 1 stereo, 2 random per sample
	task automatic send_samples(input int n, input int mode_sel, input bit back_to_back);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] l;
		logic [7:0] r;
		logic       st;
		int         gap;
		@(posedge clk_32);
		for (int i = 0; i < n; i++) begin
			a  = $random(seed);
			b  = $random(seed);
			c  = $random(seed);
			l  = $random(seed);
			r  = $random(seed);
			st = (mode_sel == 2) ? 1'($random(seed)) : mode_sel[0];
			offer_sample(a, b, c, l, r, st);
			if (!back_to_back) begin
				in_valid_i <= 1'b0;
				gap = {$random(seed)} % gap_max;
				repeat (gap) @(posedge clk_32);
			end
		end
		in_valid_i <= 1'b0;
	endtask

	// wait until the last sample has reached the converters
	task automatic drain();
		wait_ready_edge();
		repeat (div + 2) @(posedge clk_32);
	endtask

	task automatic end_test(input string name, input int err_mark);
		n_tests++;
		if (n_errors == err_mark) begin
			$display("test %-14s ok", name);
		end else begin
			n_fail_tests++;
			$display("test %-14s FAILED with %0d errors", name, n_errors - err_mark);
		end
	endtask

	initial begin : main
		int               err_mark;
		int               x0;
		int               l0;
		int               ones_l;
		int               ones_r;
		int               m_ones_l;
		int               m_ones_r;
		int               w_l;
		int               w_r;
		logic [7:0]       v [5];
		seed         = 32'hfdf2;
		xsint        = 1'b0;
		psg_a_i      = '0;
		psg_b_i      = '0;
		psg_c_i      = '0;
		dma_l_i      = '0;
		dma_r_i      = '0;
		psg_stereo_i = 1'b0;
		in_valid_i   = 1'b0;
		check_on     = 1'b0;
		n_checks     = 0;
		n_errors     = 0;
		n_tests      = 0;
		n_fail_tests = 0;
		side_diff    = 0;
		xfer_seen    = 0;
		load_seen    = 0;

		// reset values, held and just after release
		err_mark = n_errors;
		repeat (10) begin
			@(negedge clk_32);
			check_equal("in_ready_o in reset", in_ready_o, 1);
			check_equal("audio_l_o in reset", audio_l_o, 0);
			check_equal("audio_r_o in reset", audio_r_o, 0);
		end
		@(posedge clk_32);
		xsint <= 1'b1;
		@(negedge clk_32);
		check_equal("in_ready_o after reset", in_ready_o, 1);
		check_equal("audio_l_o after reset", audio_l_o, 0);
		check_equal("audio_r_o after reset", audio_r_o, 0);
		check_on = 1'b1;
		end_test("reset", err_mark);

		err_mark = n_errors;
		send_samples(n_mono, 0, 1'b0);
		drain();
		end_test("mono", err_mark);

		err_mark  = n_errors;
		side_diff = 0;
		send_samples(n_stereo, 1, 1'b0);
		drain();
		check_equal("stereo sides differ", side_diff != 0, 1);
		end_test("stereo", err_mark);

		// valid held high, ready throttles
		err_mark = n_errors;
		x0 = xfer_seen;
		l0 = load_seen;
		send_samples(n_bp, 2, 1'b1);
		drain();
		check_equal("transfers", xfer_seen - x0, n_bp);
		check_equal("loads", load_seen - l0, n_bp);
		end_test("back-pressure", err_mark);

		// one constant sample, count ones after its load
		err_mark = n_errors;
		for (int i = 0; i < 5; i++) v[i] = $random(seed);
		w_l = int'(expected_mix(v[0], v[1], v[2], v[3], 1'b1, 0) ^ 15'h4000);
		w_r = int'(expected_mix(v[0], v[1], v[2], v[4], 1'b1, 1) ^ 15'h4000);
		@(posedge clk_32);
		offer_sample(v[0], v[1], v[2], v[3], v[4], 1'b1);
		in_valid_i <= 1'b0;
		do @(negedge clk_32); while (!UUT.feed.load);  // next edge loads
		@(negedge clk_32);  // bit of the load edge, still old word
		ones_l   = 0;
		ones_r   = 0;
		m_ones_l = 0;
		m_ones_r = 0;
		repeat (dens_len) begin
			@(negedge clk_32);
			ones_l   += audio_l_o;
			ones_r   += audio_r_o;
			m_ones_l += m_bit[0];
			m_ones_r += m_bit[1];
		end
		check_equal("left ones", ones_l, m_ones_l);
		check_equal("right ones", ones_r, m_ones_r);
		check_equal("left density", (ones_l - ((dens_len * w_l) >> 15)) inside {0, 1}, 1);
		check_equal("right density", (ones_r - ((dens_len * w_r) >> 15)) inside {0, 1}, 1);
		end_test("density", err_mark);

		n_errors += UUT.u_mixer.u_assert.fail_count;  // bound assertion failures
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			n_tests, n_fail_tests, n_checks, n_errors);
		if (n_errors == 0 && n_fail_tests == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// stop a stuck run
	initial begin
		#(run_cycles * 40 + 5000);
		$display("timeout: simulation did not finish within %0d ns", run_cycles * 40 + 5000);
		$display("Some tests failed");
		$finish;
	end

endmodule
